// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

    // pc and instruction word width
    localparam int ADDR_W = 32;

    // instruction bus carries two words per beat
    localparam int BUS_W = 64;

    // boot rom entry
    localparam logic [ADDR_W-1:0] RESET_PC = 32'hbfc00000;

    // general exception entry
    localparam logic [ADDR_W-1:0] EXC_VECTOR = 32'hbfc00380;

    // commit-time redirect causes, highest priority first
    typedef enum logic [2:0] {
        RD_NONE,
        RD_EXCEPTION,
        RD_ERET,
        RD_BRANCH,
        RD_JUMP
    } redirect_kind_t;

    // phases of the four-phase instruction bus
    // request side walks idle, req, wait_drop
    // response side uses discard for a dropped beat
    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_REQ,
        BUS_WAIT_DROP,
        BUS_DISCARD
    } bus_state_t;

endpackage

// ==== hw/redirect_select.sv ====
`timescale 1ns/1ps

module redirect_select (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           exception_valid,
    input  logic                           eret,
    input  logic [fetch_pkg::ADDR_W-1:0]   epc,
    input  logic                           branch,
    input  logic [fetch_pkg::ADDR_W-1:0]   branch_target,
    input  logic                           jump,
    input  logic [fetch_pkg::ADDR_W-1:0]   jump_target,
    output logic                           redirect_valid,
    output logic [fetch_pkg::ADDR_W-1:0]   redirect_pc,
    output fetch_pkg::redirect_kind_t      redirect_kind
);
    import fetch_pkg::*;

    // fixed priority: exception, eret, branch, jump
    always_comb
    begin
        redirect_kind = RD_NONE;
        redirect_pc = '0;
        if (exception_valid)
        begin
            redirect_kind = RD_EXCEPTION;
            redirect_pc = EXC_VECTOR;
        end
        else if (eret)
        begin
            redirect_kind = RD_ERET;
            redirect_pc = epc;
        end
        else if (branch)
        begin
            redirect_kind = RD_BRANCH;
            redirect_pc = branch_target;
        end
        else if (jump)
        begin
            redirect_kind = RD_JUMP;
            redirect_pc = jump_target;
        end
    end

    // any winning cause redirects fetch this cycle
    assign redirect_valid = (redirect_kind != RD_NONE);

endmodule

// ==== hw/pc_request.sv ====
`timescale 1ns/1ps

module pc_request (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [fetch_pkg::ADDR_W-1:0]   next_pc,
    input  logic                           start,
    input  logic                           imem_ack,
    output logic                           imem_req,
    output logic [fetch_pkg::ADDR_W-1:0]   imem_addr,
    output logic [fetch_pkg::ADDR_W-1:0]   pc,
    output logic                           addr_done
);
    import fetch_pkg::*;

    bus_state_t state;
    bus_state_t state_next;
    logic       bus_free;
    logic       launch;

    // previous handshake fully closed, ack back low
    assign bus_free = (state != BUS_REQ) && !imem_ack;
    assign launch = bus_free && start;

    always_comb
    begin
        state_next = state;
        case (state)
            BUS_IDLE, BUS_WAIT_DROP:
            begin
                if (launch)
                    state_next = BUS_REQ;
                else if (!imem_ack)
                    state_next = BUS_IDLE;
            end
            BUS_REQ:
            begin
                // drop req the cycle after ack is seen
                if (imem_ack)
                    state_next = BUS_WAIT_DROP;
            end
            default:
                state_next = BUS_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state <= BUS_IDLE;
            pc <= RESET_PC;
        end
        else
        begin
            state <= state_next;
            if (launch)
                pc <= next_pc;
        end
    end

    assign imem_req = (state == BUS_REQ);

    // bus is doubleword wide, slot pick happens on the response side
    assign imem_addr = {pc[ADDR_W-1:3], 3'b000};

    // first ack of the open request
    assign addr_done = (state == BUS_REQ) && imem_ack;

endmodule

// ==== hw/instr_receive.sv ====
`timescale 1ns/1ps

module instr_receive (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           imem_ack,
    input  logic [fetch_pkg::BUS_W-1:0]    imem_data,
    input  logic [fetch_pkg::ADDR_W-1:0]   pc,
    input  logic                           discard,
    input  logic                           stall,
    output logic [fetch_pkg::ADDR_W-1:0]   instr0,
    output logic [fetch_pkg::ADDR_W-1:0]   instr1,
    output logic [fetch_pkg::ADDR_W-1:0]   pc0,
    output logic [fetch_pkg::ADDR_W-1:0]   pc1,
    output logic [1:0]                     hit,
    output logic                           full,
    output logic                           finish_instr
);
    import fetch_pkg::*;

    bus_state_t resp_state;
    logic       first_ack;
    logic       capture;

    // only the rising ack carries a fresh beat
    assign first_ack = (resp_state == BUS_IDLE) && imem_ack;
    assign capture = first_ack && !discard;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            resp_state <= BUS_IDLE;
            full <= 1'b0;
            hit <= 2'b00;
        end
        else
        begin
            case (resp_state)
                BUS_IDLE:
                begin
                    if (first_ack)
                        resp_state <= discard ? BUS_DISCARD : BUS_WAIT_DROP;
                end
                BUS_WAIT_DROP, BUS_DISCARD:
                begin
                    // wait for the memory to close the handshake
                    if (!imem_ack)
                        resp_state <= BUS_IDLE;
                end
                default:
                    resp_state <= BUS_IDLE;
            endcase

            if (discard)
                full <= 1'b0;
            else if (capture)
            begin
                full <= 1'b1;
                // upper word start leaves only slot 0
                hit <= pc[2] ? 2'b01 : 2'b11;
            end
            else if (full && !stall)
                full <= 1'b0;
        end
    end

    // low word sits at the aligned address
    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            pc0 <= pc;
            pc1 <= pc + ADDR_W'(4);
            if (pc[2])
            begin
                instr0 <= imem_data[BUS_W-1:ADDR_W];
                instr1 <= '0;
            end
            else
            begin
                instr0 <= imem_data[ADDR_W-1:0];
                instr1 <= imem_data[BUS_W-1:ADDR_W];
            end
        end
    end

    // bundle on offer whenever decode is not stalled
    assign finish_instr = full && !stall;

endmodule

// ==== hw/quickfetch.sv ====
`timescale 1ns/1ps

module quickfetch (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           stall_f,
    input  logic                           redirect_valid,
    input  logic [fetch_pkg::ADDR_W-1:0]   redirect_pc,
    input  logic                           imem_ack,
    input  logic [fetch_pkg::BUS_W-1:0]    imem_data,
    output logic                           imem_req,
    output logic [fetch_pkg::ADDR_W-1:0]   imem_addr,
    output logic [fetch_pkg::ADDR_W-1:0]   pc_f,
    output logic [fetch_pkg::ADDR_W-1:0]   instr0,
    output logic [fetch_pkg::ADDR_W-1:0]   instr1,
    output logic [fetch_pkg::ADDR_W-1:0]   pc0,
    output logic [fetch_pkg::ADDR_W-1:0]   pc1,
    output logic [1:0]                     hit_f,
    output logic                           finish_f
);
    import fetch_pkg::*;

    logic [ADDR_W-1:0] next_pc;
    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] seq_pc;
    logic [ADDR_W-1:0] seq_pc_;
    logic [ADDR_W-1:0] redir_pc_h;
    logic [ADDR_W-1:0] redir_pc_h_;
    logic              redir_h;
    logic              redir_h_;
    logic              mask;
    logic              mask_;
    logic              start;
    logic              open_txn;
    logic              addr_done;
    logic              discard;
    logic              full;
    logic              finish_instr;

    // live redirect first, then a held one, else sequential
    assign next_pc = redirect_valid ? redirect_pc : (redir_h ? redir_pc_h : seq_pc);

    // bus closed and output buffer empty
    assign start = !imem_req && !imem_ack && !full;

    // request out, ack not yet back
    assign open_txn = imem_req && !imem_ack;

    // kill the beat of a marked transaction or one hit by a redirect now
    assign discard = redirect_valid || mask;

    always_comb
    begin
        seq_pc_ = seq_pc;
        redir_h_ = redir_h;
        redir_pc_h_ = redir_pc_h;
        mask_ = mask;
        if (addr_done)
        begin
            mask_ = 1'b0;
            // only a kept beat moves the sequential pc
            if (!discard)
                seq_pc_ = pc[2] ? pc + ADDR_W'(4) : pc + ADDR_W'(8);
        end
        if (start)
            redir_h_ = 1'b0;
        if (redirect_valid)
        begin
            if (open_txn)
                mask_ = 1'b1;
            // bus busy, keep the target until the next request
            if (!start)
            begin
                redir_h_ = 1'b1;
                redir_pc_h_ = redirect_pc;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            seq_pc <= RESET_PC;
            redir_h <= 1'b0;
            mask <= 1'b0;
        end
        else
        begin
            seq_pc <= seq_pc_;
            redir_h <= redir_h_;
            mask <= mask_;
        end
    end

    always_ff @(posedge clk)
    begin
        redir_pc_h <= redir_pc_h_;
    end

    pc_request pc_request (
        .clk,
        .reset,
        .next_pc,
        .start,
        .imem_ack,
        .imem_req,
        .imem_addr,
        .pc,
        .addr_done
    );

    instr_receive instr_receive (
        .clk,
        .reset,
        .imem_ack,
        .imem_data,
        .pc,
        .discard,
        .stall(stall_f),
        .instr0,
        .instr1,
        .pc0,
        .pc1,
        .hit(hit_f),
        .full,
        .finish_instr
    );

    assign pc_f = pc;

    // a redirect this cycle kills the bundle on offer
    assign finish_f = finish_instr && !redirect_valid;

endmodule

// ==== hw/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           exception_valid,
    input  logic                           eret,
    input  logic [fetch_pkg::ADDR_W-1:0]   epc,
    input  logic                           branch,
    input  logic [fetch_pkg::ADDR_W-1:0]   branch_target,
    input  logic                           jump,
    input  logic [fetch_pkg::ADDR_W-1:0]   jump_target,
    input  logic                           stall_f,
    output logic [fetch_pkg::ADDR_W-1:0]   pc_f,
    output logic [fetch_pkg::ADDR_W-1:0]   instr0,
    output logic [fetch_pkg::ADDR_W-1:0]   instr1,
    output logic [fetch_pkg::ADDR_W-1:0]   pc0,
    output logic [fetch_pkg::ADDR_W-1:0]   pc1,
    output logic [1:0]                     hit_f,
    output logic                           finish_f,
    output logic                           imem_req,
    output logic [fetch_pkg::ADDR_W-1:0]   imem_addr,
    input  logic                           imem_ack,
    input  logic [fetch_pkg::BUS_W-1:0]    imem_data
);
    import fetch_pkg::*;

    logic              redirect_valid;
    logic [ADDR_W-1:0] redirect_pc;

    // cause is visible on the waveform through the instance port
    redirect_select redirect_select (
        .clk,
        .reset,
        .exception_valid,
        .eret,
        .epc,
        .branch,
        .branch_target,
        .jump,
        .jump_target,
        .redirect_valid,
        .redirect_pc,
        .redirect_kind()
    );

    quickfetch quickfetch (
        .clk,
        .reset,
        .stall_f,
        .redirect_valid,
        .redirect_pc,
        .imem_ack,
        .imem_data,
        .imem_req,
        .imem_addr,
        .pc_f,
        .instr0,
        .instr1,
        .pc0,
        .pc1,
        .hit_f,
        .finish_f
    );

endmodule

// ==== bench/fetch_props.sv ====
`timescale 1ns/1ps

module fetch_props (
    input logic                           clk,
    input logic                           reset,
    input logic                           imem_req,
    input logic                           imem_ack,
    input logic [fetch_pkg::ADDR_W-1:0]   imem_addr,
    input logic                           stall_f,
    input logic                           full,
    input logic [fetch_pkg::ADDR_W-1:0]   instr0,
    input logic [fetch_pkg::ADDR_W-1:0]   instr1,
    input logic [fetch_pkg::ADDR_W-1:0]   pc0,
    input logic [fetch_pkg::ADDR_W-1:0]   pc1,
    input logic [1:0]                     hit_f
);
    // req may only fall once ack has been seen
    req_held: assert property (@(posedge clk) disable iff (!reset)
        imem_req && !imem_ack |=> imem_req)
        else $error("imem_req dropped before imem_ack");

    addr_stable: assert property (@(posedge clk) disable iff (!reset)
        imem_req |=> !imem_req || $stable(imem_addr))
        else $error("imem_addr changed while imem_req high");

    // captured bundle frozen while decode stalls
    bundle_held: assert property (@(posedge clk) disable iff (!reset)
        full && stall_f |=> $stable({instr0, instr1, pc0, pc1, hit_f}))
        else $error("bundle changed during stall_f");

endmodule

bind quickfetch fetch_props props (
    .clk,
    .reset,
    .imem_req,
    .imem_ack,
    .imem_addr,
    .stall_f,
    .full,
    .instr0,
    .instr1,
    .pc0,
    .pc1,
    .hit_f
);

// ==== bench/fetch_tb_clock.sv ====
`timescale 1ns/1ps

module fetch_tb_clock (
    output logic clk,
    output logic reset
);
    // 10 ns period
    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // low through the first 4 rising edges, released on a falling edge
    initial
    begin
        reset = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b1;
    end

endmodule

// ==== bench/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;
    import fetch_pkg::*;

    localparam logic [31:0] LFSR_SEED = 32'h38d6_6117;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam logic [31:0] WORD_KEY = 32'h5a5a_0000;
    localparam logic [31:0] TARGET_BASE = 32'h0040_0000;
    localparam int ACK_DELAY_SPAN = 6;
    localparam int DROP_DELAY_SPAN = 3;
    localparam int WAIT_LIMIT = 300;
    localparam int RANDOM_CYCLES = 3000;

    logic              clk;
    logic              reset;
    logic              exception_valid;
    logic              eret;
    logic [ADDR_W-1:0] epc;
    logic              branch;
    logic [ADDR_W-1:0] branch_target;
    logic              jump;
    logic [ADDR_W-1:0] jump_target;
    logic              stall_f;
    logic [ADDR_W-1:0] pc_f;
    logic [ADDR_W-1:0] instr0;
    logic [ADDR_W-1:0] instr1;
    logic [ADDR_W-1:0] pc0;
    logic [ADDR_W-1:0] pc1;
    logic [1:0]        hit_f;
    logic              finish_f;
    logic              imem_req;
    logic [ADDR_W-1:0] imem_addr;
    logic              imem_ack;
    logic [BUS_W-1:0]  imem_data;

    logic [ADDR_W-1:0] exp_pc;
    logic [ADDR_W-1:0] last_pc0;
    logic [129:0]      exp_bundle;
    logic [31:0]       stim_rng;
    logic [31:0]       mem_rng;
    int                mem_min_delay;
    int                bundles;
    bit                passed;
    bit                failed_shown;

    fetch_tb_clock clock_gen (.clk, .reset);

    fetch_top dut (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic draw(inout logic [31:0] state, input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            state = lfsr_next(state);
            val = {val[30:0], state[0]};
        end
    endtask

    function automatic logic [ADDR_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
        return addr ^ WORD_KEY;
    endfunction

    // reference bundle {instr0, instr1, pc0, pc1, hit} for a fetch at pc
    function automatic logic [129:0] expected_bundle(input logic [ADDR_W-1:0] pc);
        logic [ADDR_W-1:0] second;
        logic [1:0]        hit;
        second = pc[2] ? '0 : mem_word(pc + 32'd4);
        hit = pc[2] ? 2'b01 : 2'b11;
        return {mem_word(pc), second, pc, pc + 32'd4, hit};
    endfunction

    // upper word start yields a single slot
    function automatic logic [ADDR_W-1:0] next_fetch_pc(input logic [ADDR_W-1:0] pc);
        return pc[2] ? pc + 32'd4 : pc + 32'd8;
    endfunction

    function automatic logic [ADDR_W-1:0] redirect_target(
        input logic              exc,
        input logic              er,
        input logic [ADDR_W-1:0] er_pc,
        input logic              br,
        input logic [ADDR_W-1:0] br_pc,
        input logic [ADDR_W-1:0] jmp_pc
    );
        if (exc)
            return EXC_VECTOR;
        if (er)
            return er_pc;
        if (br)
            return br_pc;
        return jmp_pc;
    endfunction

    task automatic stop_failed();
        failed_shown = 1'b1;
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            stop_failed();
        end
    endtask

    task automatic wait_bundles(input int target);
        int n;
        n = 0;
        while (bundles < target)
        begin
            if (n == WAIT_LIMIT)
            begin
                $display("timed out waiting for bundle %0d, saw %0d", target, bundles);
                stop_failed();
            end
            else
            begin
                n++;
                @(negedge clk);
            end
        end
    endtask

    // a fresh request, low before high
    task automatic wait_req_rise();
        int   n;
        logic seen_low;
        n = 0;
        seen_low = 1'b0;
        while (!(seen_low && imem_req))
        begin
            if (n == WAIT_LIMIT)
            begin
                $display("timed out waiting for imem_req to rise");
                stop_failed();
            end
            else
            begin
                seen_low = seen_low || !imem_req;
                n++;
                @(negedge clk);
            end
        end
    endtask

    task automatic pulse_redirect(input logic exc, input logic er, input logic br,
                                  input logic jmp);
        @(negedge clk);
        exception_valid = exc;
        eret = er;
        branch = br;
        jump = jmp;
        @(negedge clk);
        exception_valid = 1'b0;
        eret = 1'b0;
        branch = 1'b0;
        jump = 1'b0;
    endtask

    // memory model on the falling edge
    initial
    begin
        logic [31:0] d;
        int          n;
        imem_ack = 1'b0;
        imem_data = '0;
        mem_rng = LFSR_SEED;
        // memory stream runs 32 steps ahead of the stimulus stream
        for (int i = 0; i < 32; i++)
            mem_rng = lfsr_next(mem_rng);
        forever
        begin
            @(negedge clk);
            if (reset && imem_req && !imem_ack)
            begin
                // every request fetches the doubleword holding the expected pc
                check("imem_addr", imem_addr, {exp_pc[ADDR_W-1:3], 3'b000});
                draw(mem_rng, 3, d);
                d = d % ACK_DELAY_SPAN;
                if (d < mem_min_delay)
                    d = mem_min_delay;
                repeat (d) @(negedge clk);
                imem_data = {mem_word(imem_addr + 32'd4), mem_word(imem_addr)};
                imem_ack = 1'b1;
                n = 0;
                while (imem_req)
                begin
                    if (n == WAIT_LIMIT)
                    begin
                        $display("imem_req never dropped after imem_ack");
                        stop_failed();
                    end
                    else
                    begin
                        n++;
                        @(negedge clk);
                    end
                end
                draw(mem_rng, 2, d);
                repeat (d % DROP_DELAY_SPAN) @(negedge clk);
                imem_ack = 1'b0;
            end
        end
    end

    // compare every delivered bundle with the reference stream
    always @(posedge clk)
    begin
        if (reset)
        begin
            if (exception_valid || eret || branch || jump)
            begin
                check("finish_f", 32'(finish_f), 32'd0);
                exp_pc = redirect_target(exception_valid, eret, epc, branch,
                                         branch_target, jump_target);
            end
            else if (finish_f)
            begin
                exp_bundle = expected_bundle(exp_pc);
                check("instr0", instr0, exp_bundle[129:98]);
                check("instr1", instr1, exp_bundle[97:66]);
                check("pc0", pc0, exp_bundle[65:34]);
                check("pc1", pc1, exp_bundle[33:2]);
                check("hit_f", 32'(hit_f), 32'(exp_bundle[1:0]));
                check("pc_f", pc_f, exp_bundle[65:34]);
                last_pc0 = pc0;
                exp_pc = next_fetch_pc(exp_pc);
                bundles++;
            end
        end
    end

    initial
    begin
        logic [31:0] r;
        logic [31:0] causes;
        int          last_count;
        int          idle;
        exception_valid = 1'b0;
        eret = 1'b0;
        epc = '0;
        branch = 1'b0;
        branch_target = '0;
        jump = 1'b0;
        jump_target = '0;
        stall_f = 1'b0;
        stim_rng = LFSR_SEED;
        exp_pc = RESET_PC;
        mem_min_delay = 0;
        bundles = 0;

        // outputs quiet while reset is held
        repeat (3) @(negedge clk);
        check("imem_req", 32'(imem_req), 32'd0);
        check("finish_f", 32'(finish_f), 32'd0);
        check("hit_f", 32'(hit_f), 32'd0);

        // boot fetch and sequential pairs
        wait_req_rise();
        check("imem_addr", imem_addr, RESET_PC);
        wait_bundles(4);

        // jump onto an upper word
        jump_target = TARGET_BASE | 32'h1004;
        pulse_redirect(1'b0, 1'b0, 1'b0, 1'b1);
        wait_bundles(bundles + 1);
        check("pc0", last_pc0, jump_target);
        wait_bundles(bundles + 3);

        for (int i = 0; i < 80; i++)
        begin
            @(negedge clk);
            draw(stim_rng, 1, r);
            stall_f = r[0];
        end
        stall_f = 1'b0;
        wait_bundles(bundles + 2);

        // slow memory keeps the transaction open under the branch
        mem_min_delay = 3;
        branch_target = TARGET_BASE | 32'h2000;
        wait_req_rise();
        pulse_redirect(1'b0, 1'b0, 1'b1, 1'b0);
        mem_min_delay = 0;
        wait_bundles(bundles + 1);
        check("pc0", last_pc0, branch_target);

        epc = TARGET_BASE | 32'h3000;
        branch_target = TARGET_BASE | 32'h4000;
        jump_target = TARGET_BASE | 32'h5000;
        pulse_redirect(1'b1, 1'b1, 1'b1, 1'b1);
        wait_bundles(bundles + 1);
        check("pc0", last_pc0, EXC_VECTOR);
        pulse_redirect(1'b0, 1'b1, 1'b1, 1'b0);
        wait_bundles(bundles + 1);
        check("pc0", last_pc0, epc);
        pulse_redirect(1'b0, 1'b0, 1'b1, 1'b1);
        wait_bundles(bundles + 1);
        check("pc0", last_pc0, branch_target);

        // mixed stalls, redirects and memory delays
        last_count = bundles;
        idle = 0;
        for (int cyc = 0; cyc < RANDOM_CYCLES; cyc++)
        begin
            @(negedge clk);
            draw(stim_rng, 2, r);
            stall_f = (r == 0);
            draw(stim_rng, 4, r);
            causes = '0;
            if (r == 0)
            begin
                draw(stim_rng, 4, causes);
                draw(stim_rng, 14, r);
                epc = TARGET_BASE | (r << 2);
                draw(stim_rng, 14, r);
                branch_target = TARGET_BASE | (r << 2);
                draw(stim_rng, 14, r);
                jump_target = TARGET_BASE | (r << 2);
            end
            exception_valid = causes[0];
            eret = causes[1];
            branch = causes[2];
            jump = causes[3];
            if (bundles != last_count)
            begin
                last_count = bundles;
                idle = 0;
            end
            else if (idle == WAIT_LIMIT)
            begin
                $display("no bundle delivered for %0d cycles", WAIT_LIMIT);
                stop_failed();
            end
            else
                idle++;
        end
        stall_f = 1'b0;
        exception_valid = 1'b0;
        eret = 1'b0;
        branch = 1'b0;
        jump = 1'b0;
        wait_bundles(bundles + 2);

        if (bundles < 100)
        begin
            $display("only %0d bundles delivered over the whole run", bundles);
            stop_failed();
        end
        else
        begin
            passed = 1'b1;
            $display("Result: PASSED");
            $finish;
        end
    end

    final
    begin
        if (!passed && !failed_shown)
            $display("Result: FAILED");
    end

endmodule

// ==== flist.f ====
hw/fetch_pkg.sv
hw/redirect_select.sv
hw/pc_request.sv
hw/instr_receive.sv
hw/quickfetch.sv
hw/fetch_top.sv
bench/fetch_props.sv
bench/fetch_tb_clock.sv
bench/fetch_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module fetch_tb -f flist.f \
    --Mdir obj_dir -o fetch_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/fetch_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Result: PASSED$"; then
    exit 0
fi
echo "pass message not found"
exit 1
